// File: hdl/ex_defines.svh
`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

// Data path width
`define EX_XLEN 32

// Scoreboard tag width
`define EX_TRANS_ID_W 3

// CSR address field
`define EX_CSR_ADDR_W 12

// Next-PC step for normal and compressed encodings
`define EX_LINK_INC 4
`define EX_LINK_INC_C 2

`endif

// File: hdl/ex_op_pkg.sv
package ex_op_pkg;

    // Operators of the fixed-latency units
    typedef enum logic [4:0] {
        ADD, SUB, AND, OR, XOR,
        SLL, SRL, SRA,
        SLT, SLTU,
        EQ, NE, LTS, GES, LTU, GEU,
        JALR,
        CSR_RW,
        MUL, MULH, MULHU, MULHSU
    } fu_op_e;

    // Unit that owns an operator
    typedef enum logic [2:0] {
        CLS_ALU,
        CLS_BRANCH,
        CLS_CSR,
        CLS_MULT,
        CLS_INVALID
    } op_class_e;

    // Signedness of operand a then operand b
    typedef enum logic [1:0] {
        SGN_UU,
        SGN_SU,
        SGN_SS
    } op_sign_e;

    function automatic op_class_e op_class(fu_op_e op);
        op_class_e cls;
        case (op)
            ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU: cls = CLS_ALU;
            EQ, NE, LTS, GES, LTU, GEU, JALR:                  cls = CLS_BRANCH;
            CSR_RW:                                           cls = CLS_CSR;
            MUL, MULH, MULHU, MULHSU:                         cls = CLS_MULT;
            default:                                          cls = CLS_INVALID;
        endcase
        return cls;
    endfunction

    function automatic op_sign_e op_sign(fu_op_e op);
        op_sign_e sgn;
        case (op)
            SLT, LTS, GES, MUL, MULH: sgn = SGN_SS;
            MULHSU:                   sgn = SGN_SU;
            default:                  sgn = SGN_UU;
        endcase
        return sgn;
    endfunction

endpackage

// File: hdl/ex_data_pkg.sv
`include "ex_defines.svh"

package ex_data_pkg;

    // Upper bits above the CSR address in the immediate word
    localparam int unsigned CSR_PAD_W = `EX_XLEN - `EX_CSR_ADDR_W;

    // Width of PC, targets and link address on the resolve port
    localparam int unsigned RESOLVE_TARGET_W = `EX_XLEN;

    // --------------------------------------------------
    // Immediate word decoded per unit
    // --------------------------------------------------
    // Branches and jalr read a sign-extended offset
    // CSR ops read the address in the low bits
    typedef union packed {
        logic signed [`EX_XLEN-1:0] offset;
        struct packed {
            logic [CSR_PAD_W-1:0]      pad;
            logic [`EX_CSR_ADDR_W-1:0] addr;
        } csr;
    } imm_word_u;

endpackage

// File: hdl/ex_alu.sv
`timescale 1ns/10ps
`include "ex_defines.svh"

module ex_alu (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  ex_op_pkg::fu_op_e   operator_i,
    input  logic [`EX_XLEN-1:0] operand_a_i,
    input  logic [`EX_XLEN-1:0] operand_b_i,
    output logic [`EX_XLEN-1:0] result_o,
    output logic                branch_cmp_o
);
    import ex_op_pkg::*;

    localparam int unsigned SHAMT_W = $clog2(`EX_XLEN);

    logic               cmp_signed;
    logic [`EX_XLEN:0]  cmp_diff;
    logic               less;
    logic               equal;
    logic [SHAMT_W-1:0] shamt;

    // --------------------------------------------------
    // Shared comparator
    // --------------------------------------------------
    // One extra bit so the sign of the difference is the less-than flag
    assign cmp_signed = (op_sign(operator_i) == SGN_SS);
    assign cmp_diff   = {cmp_signed & operand_a_i[`EX_XLEN-1], operand_a_i}
                      - {cmp_signed & operand_b_i[`EX_XLEN-1], operand_b_i};
    assign less       = cmp_diff[`EX_XLEN];
    assign equal      = (operand_a_i == operand_b_i);

    // Only low bits of b count as shift amount
    assign shamt = operand_b_i[SHAMT_W-1:0];

    // --------------------------------------------------
    // Result select
    // --------------------------------------------------
    always_comb begin
        result_o = '0;
        case (operator_i)
            ADD:       result_o = operand_a_i + operand_b_i;
            SUB:       result_o = operand_a_i - operand_b_i;
            AND:       result_o = operand_a_i & operand_b_i;
            OR:        result_o = operand_a_i | operand_b_i;
            XOR:       result_o = operand_a_i ^ operand_b_i;
            SLL:       result_o = operand_a_i << shamt;
            SRL:       result_o = operand_a_i >> shamt;
            // Arithmetic shift keeps the sign
            SRA:       result_o = $unsigned($signed(operand_a_i) >>> shamt);
            SLT, SLTU: result_o = {{(`EX_XLEN-1){1'b0}}, less};
            default:   result_o = '0;
        endcase
    end

    // Branch condition for the branch unit
    always_comb begin
        branch_cmp_o = 1'b0;
        case (operator_i)
            EQ:       branch_cmp_o = equal;
            NE:       branch_cmp_o = ~equal;
            LTS, LTU: branch_cmp_o = less;
            GES, GEU: branch_cmp_o = ~less;
            default:  branch_cmp_o = 1'b0;
        endcase
    end

    // Issuer never presents an undefined encoding
    a_op_defined: assert property (@(posedge clk_i) disable iff (!rst_ni)
        op_class(operator_i) != CLS_INVALID);

endmodule

// File: hdl/ex_branch_unit.sv
`timescale 1ns/10ps
`include "ex_defines.svh"

module ex_branch_unit (
    input  ex_op_pkg::fu_op_e                        operator_i,
    input  logic [ex_data_pkg::RESOLVE_TARGET_W-1:0] pc_i,
    input  logic                                     is_compressed_i,
    input  logic [`EX_XLEN-1:0]                      operand_a_i,
    input  ex_data_pkg::imm_word_u                   imm_i,
    input  logic                                     branch_valid_i,
    input  logic                                     branch_cmp_i,
    input  logic                                     predict_taken_i,
    input  logic [ex_data_pkg::RESOLVE_TARGET_W-1:0] predict_target_i,
    output logic [ex_data_pkg::RESOLVE_TARGET_W-1:0] link_o,
    output logic                                     resolve_valid_o,
    output logic                                     resolve_taken_o,
    output logic [ex_data_pkg::RESOLVE_TARGET_W-1:0] resolve_target_o,
    output logic                                     resolve_mispredict_o
);
    import ex_op_pkg::*;
    import ex_data_pkg::*;

    logic                        is_jalr;
    logic                        taken;
    logic [RESOLVE_TARGET_W-1:0] target_base;
    logic [RESOLVE_TARGET_W-1:0] target_sum;
    logic [RESOLVE_TARGET_W-1:0] jump_target;

    assign is_jalr = (operator_i == JALR);

    // Return address step depends on encoding size
    assign link_o = pc_i + (is_compressed_i ? RESOLVE_TARGET_W'(`EX_LINK_INC_C)
                                            : RESOLVE_TARGET_W'(`EX_LINK_INC));

    // --------------------------------------------------
    // Target computation
    // --------------------------------------------------
    // jalr is register relative, branches are PC relative
    assign target_base = is_jalr ? operand_a_i : pc_i;
    assign target_sum  = target_base + imm_i.offset;
    // Bit 0 dropped for jalr only
    assign jump_target = is_jalr ? {target_sum[RESOLVE_TARGET_W-1:1], 1'b0} : target_sum;

    assign taken = is_jalr | branch_cmp_i;

    assign resolve_valid_o  = branch_valid_i;
    assign resolve_taken_o  = branch_valid_i & taken;
    // Not taken falls through to the next instruction
    assign resolve_target_o = taken ? jump_target : link_o;

    // Direction wrong, or both taken but to different places
    assign resolve_mispredict_o = branch_valid_i
                                & ((predict_taken_i != taken)
                                 | (taken & (predict_target_i != jump_target)));

endmodule

// File: hdl/ex_csr_buffer.sv
`timescale 1ns/10ps
`include "ex_defines.svh"

module ex_csr_buffer (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      flush_i,
    input  logic                      csr_valid_i,
    input  ex_data_pkg::imm_word_u    imm_i,
    input  logic [`EX_XLEN-1:0]       operand_a_i,
    input  logic                      csr_commit_i,
    output logic                      csr_ready_o,
    output logic [`EX_XLEN-1:0]       csr_result_o,
    output logic [`EX_CSR_ADDR_W-1:0] csr_addr_o
);

    logic                      full_q;
    logic                      full_d;
    logic [`EX_CSR_ADDR_W-1:0] addr_q;

    // Write-back value is rs1 itself, CSR read happens at commit
    assign csr_result_o = operand_a_i;
    assign csr_addr_o   = addr_q;

    // Free slot, or the held entry retires this cycle
    assign csr_ready_o = ~full_q | csr_commit_i;

    // Commit frees, new issue refills, flush wins over both
    always_comb begin
        full_d = full_q;
        if (csr_commit_i) begin
            full_d = 1'b0;
        end
        if (csr_valid_i) begin
            full_d = 1'b1;
        end
        if (flush_i) begin
            full_d = 1'b0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            full_q <= 1'b0;
        end else begin
            full_q <= full_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (csr_valid_i) begin
            addr_q <= imm_i.csr.addr;
        end
    end

    // Issue only into a free or retiring slot
    a_no_overfill: assert property (@(posedge clk_i) disable iff (!rst_ni)
        csr_valid_i |-> (!full_q || csr_commit_i));

endmodule

// File: hdl/ex_mult.sv
`timescale 1ns/10ps
`include "ex_defines.svh"

module ex_mult (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      flush_i,
    input  logic                      mult_valid_i,
    input  ex_op_pkg::fu_op_e         operator_i,
    input  logic [`EX_XLEN-1:0]       operand_a_i,
    input  logic [`EX_XLEN-1:0]       operand_b_i,
    input  logic [`EX_TRANS_ID_W-1:0] trans_id_i,
    output logic                      mult_valid_o,
    output logic [`EX_XLEN-1:0]       mult_result_o,
    output logic [`EX_TRANS_ID_W-1:0] mult_trans_id_o
);
    import ex_op_pkg::*;

    logic                      a_signed;
    logic                      b_signed;
    logic [2*`EX_XLEN+1:0]     product;
    logic [`EX_XLEN-1:0]       result_d;
    logic                      valid_q;
    logic [`EX_XLEN-1:0]       result_q;
    logic [`EX_TRANS_ID_W-1:0] trans_id_q;

    // --------------------------------------------------
    // Product with one sign-extension bit per operand
    // --------------------------------------------------
    assign a_signed = (op_sign(operator_i) != SGN_UU);
    assign b_signed = (op_sign(operator_i) == SGN_SS);
    assign product  = $signed({a_signed & operand_a_i[`EX_XLEN-1], operand_a_i})
                    * $signed({b_signed & operand_b_i[`EX_XLEN-1], operand_b_i});

    // mul keeps low word, the mulh family the high word
    assign result_d = (operator_i == MUL) ? product[`EX_XLEN-1:0]
                                          : product[2*`EX_XLEN-1:`EX_XLEN];

    // Dropped on flush in the issue cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= mult_valid_i & ~flush_i;
        end
    end

    always_ff @(posedge clk_i) begin
        result_q   <= result_d;
        trans_id_q <= trans_id_i;
    end

    // Flush during write-back also kills the result
    assign mult_valid_o    = valid_q & ~flush_i;
    assign mult_result_o   = result_q;
    assign mult_trans_id_o = trans_id_q;

endmodule

// File: hdl/ex_flu_top.sv
`timescale 1ns/10ps
`include "ex_defines.svh"

module ex_flu_top (
    input  logic                                     clk_i,
    input  logic                                     rst_ni,
    input  logic                                     flush_i,
    input  ex_op_pkg::fu_op_e                        operator_i,
    input  logic [`EX_XLEN-1:0]                      operand_a_i,
    input  logic [`EX_XLEN-1:0]                      operand_b_i,
    input  ex_data_pkg::imm_word_u                   imm_i,
    input  logic [`EX_TRANS_ID_W-1:0]                trans_id_i,
    input  logic [ex_data_pkg::RESOLVE_TARGET_W-1:0] pc_i,
    input  logic                                     is_compressed_i,
    input  logic                                     alu_valid_i,
    input  logic                                     branch_valid_i,
    input  logic                                     csr_valid_i,
    input  logic                                     mult_valid_i,
    input  logic                                     predict_taken_i,
    input  logic [ex_data_pkg::RESOLVE_TARGET_W-1:0] predict_target_i,
    input  logic                                     csr_commit_i,
    output logic                                     flu_valid_o,
    output logic                                     flu_ready_o,
    output logic [`EX_XLEN-1:0]                      flu_result_o,
    output logic [`EX_TRANS_ID_W-1:0]                flu_trans_id_o,
    output logic [`EX_CSR_ADDR_W-1:0]                csr_addr_o,
    output logic                                     resolve_valid_o,
    output logic                                     resolve_taken_o,
    output logic [ex_data_pkg::RESOLVE_TARGET_W-1:0] resolve_target_o,
    output logic                                     resolve_mispredict_o
);
    import ex_op_pkg::*;

    logic [`EX_XLEN-1:0]       alu_a, alu_b, alu_result;
    logic                      alu_branch_cmp;
    logic [`EX_XLEN-1:0]       branch_link;
    logic [`EX_XLEN-1:0]       csr_result;
    logic                      csr_ready;
    logic [`EX_XLEN-1:0]       mult_a, mult_b, mult_result;
    logic [`EX_TRANS_ID_W-1:0] mult_tid_in, mult_trans_id;
    logic                      mult_valid;

    // --------------------------------------------------
    // Idle units see zeroed operands
    // --------------------------------------------------
    // Branch compare runs on the ALU comparator
    assign alu_a       = (alu_valid_i | branch_valid_i) ? operand_a_i : '0;
    assign alu_b       = (alu_valid_i | branch_valid_i) ? operand_b_i : '0;
    assign mult_a      = mult_valid_i ? operand_a_i : '0;
    assign mult_b      = mult_valid_i ? operand_b_i : '0;
    assign mult_tid_in = mult_valid_i ? trans_id_i : '0;

    ex_alu u_alu (
        .clk_i, .rst_ni, .operator_i,
        .operand_a_i(alu_a), .operand_b_i(alu_b),
        .result_o(alu_result), .branch_cmp_o(alu_branch_cmp));

    ex_branch_unit u_branch (
        .operator_i, .pc_i, .is_compressed_i, .operand_a_i, .imm_i, .branch_valid_i,
        .branch_cmp_i(alu_branch_cmp), .predict_taken_i, .predict_target_i,
        .link_o(branch_link), .resolve_valid_o, .resolve_taken_o,
        .resolve_target_o, .resolve_mispredict_o);

    ex_csr_buffer u_csr (
        .clk_i, .rst_ni, .flush_i, .csr_valid_i, .imm_i, .operand_a_i, .csr_commit_i,
        .csr_ready_o(csr_ready), .csr_result_o(csr_result), .csr_addr_o);

    ex_mult u_mult (
        .clk_i, .rst_ni, .flush_i, .mult_valid_i, .operator_i,
        .operand_a_i(mult_a), .operand_b_i(mult_b), .trans_id_i(mult_tid_in),
        .mult_valid_o(mult_valid), .mult_result_o(mult_result),
        .mult_trans_id_o(mult_trans_id));

    // --------------------------------------------------
    // Write-back merge
    // --------------------------------------------------
    assign flu_valid_o = alu_valid_i | branch_valid_i | csr_valid_i | mult_valid;
    assign flu_ready_o = csr_ready;

    // Branch link is the fallback result
    always_comb begin
        flu_result_o   = branch_link;
        flu_trans_id_o = trans_id_i;
        if (alu_valid_i) begin
            flu_result_o = alu_result;
        end else if (csr_valid_i) begin
            flu_result_o = csr_result;
        end else if (mult_valid) begin
            flu_result_o   = mult_result;
            flu_trans_id_o = mult_trans_id;
        end
    end

    // Slot after a mult issue is reserved for its write-back
    a_no_collision: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mult_valid_i |=> !(alu_valid_i || branch_valid_i || csr_valid_i));

    // One select at a time, and it matches the operator's unit
    a_select_class: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({alu_valid_i, branch_valid_i, csr_valid_i, mult_valid_i})
        && (!alu_valid_i    || op_class(operator_i) == CLS_ALU)
        && (!branch_valid_i || op_class(operator_i) == CLS_BRANCH)
        && (!csr_valid_i    || op_class(operator_i) == CLS_CSR)
        && (!mult_valid_i   || op_class(operator_i) == CLS_MULT));

endmodule

// File: sim/ex_flu_checker.sv
`timescale 1ns/10ps
`include "ex_defines.svh"

module ex_flu_checker (
    input  logic                      clk_i,
    input  logic                      check_i,
    input  int                        test_i,
    // Observed write-back and resolve outputs
    input  logic                      valid_i, ready_i, res_valid_i, taken_i, mispredict_i,
    input  logic [`EX_XLEN-1:0]       result_i, target_i,
    input  logic [`EX_TRANS_ID_W-1:0] trans_id_i,
    input  logic [`EX_CSR_ADDR_W-1:0] csr_addr_i,
    // Expected values for the current slot
    input  logic                      exp_valid_i, exp_ready_i, exp_res_valid_i,
    input  logic                      exp_taken_i, exp_mis_i, exp_csr_chk_i,
    input  logic [`EX_XLEN-1:0]       exp_result_i, exp_target_i,
    input  logic [`EX_TRANS_ID_W-1:0] exp_trans_id_i,
    input  logic [`EX_CSR_ADDR_W-1:0] exp_csr_addr_i,
    output int                        tests_o,
    output int                        errors_o
);

    int tests = 0;
    int errors = 0;
    int slot_errors;

    assign tests_o  = tests;
    assign errors_o = errors;

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (got !== exp) begin
            $display("** Error: %s expected %h got %h (test %0d)", name, exp, got, test_i);
            slot_errors++;
        end
    endtask

    // --------------------------------------------------
    // Compare on the rising edge
    // --------------------------------------------------
    always @(posedge clk_i) begin
        if (check_i) begin
            slot_errors = 0;
            compare("flu_valid_o", exp_valid_i, valid_i);
            compare("flu_ready_o", exp_ready_i, ready_i);
            compare("resolve_valid_o", exp_res_valid_i, res_valid_i);
            // Payload only meaningful with its valid
            if (exp_valid_i) begin
                compare("flu_result_o", exp_result_i, result_i);
                compare("flu_trans_id_o", exp_trans_id_i, trans_id_i);
            end
            if (exp_res_valid_i) begin
                compare("resolve_taken_o", exp_taken_i, taken_i);
                compare("resolve_target_o", exp_target_i, target_i);
                compare("resolve_mispredict_o", exp_mis_i, mispredict_i);
            end
            // Held CSR address
            if (exp_csr_chk_i) begin
                compare("csr_addr_o", exp_csr_addr_i, csr_addr_i);
            end
            tests++;
            errors += slot_errors;
            $display("test %0d %s", test_i, (slot_errors == 0) ? "ok" : "mismatch");
        end
    end

endmodule

// File: sim/tb_ex_flu.sv
`timescale 1ns/10ps
`include "ex_defines.svh"

module tb_ex_flu;
    import ex_op_pkg::*;

    // One-hot unit selects
    localparam logic [3:0] SEL_NONE = 4'b0000;
    localparam logic [3:0] SEL_ALU  = 4'b0001;
    localparam logic [3:0] SEL_BR   = 4'b0010;
    localparam logic [3:0] SEL_CSR  = 4'b0100;
    localparam logic [3:0] SEL_MUL  = 4'b1000;

    // Stimulus and expected values of one table row
    typedef struct packed {
        fu_op_e                    op;
        logic [3:0]                sel;
        logic [`EX_XLEN-1:0]       a, b, imm, pc, pred_target;
        logic                      comp, pred_taken, commit, flush;
        logic [`EX_TRANS_ID_W-1:0] tid, exp_tid;
        logic                      chk, exp_valid, exp_ready, exp_res_valid;
        logic                      exp_taken, exp_mis, csr_chk;
        logic [`EX_XLEN-1:0]       exp_result, exp_target;
        logic [`EX_CSR_ADDR_W-1:0] exp_csr_addr;
    } entry_t;

    logic                      clk_i;
    logic                      rst_ni;
    logic                      table_ready = 1'b0;
    integer                    seed = 32'hb17f9e54;
    int                        cur_test = 0;
    int                        tests, errors;
    entry_t                    cur;
    entry_t                    table_q[$];
    logic                      flu_valid, flu_ready, res_valid, res_taken, res_mis;
    logic [`EX_XLEN-1:0]       flu_result, res_target;
    logic [`EX_TRANS_ID_W-1:0] flu_trans_id;
    logic [`EX_CSR_ADDR_W-1:0] csr_addr;

    ex_flu_top u_dut (
        .clk_i, .rst_ni, .flush_i(cur.flush), .operator_i(cur.op),
        .operand_a_i(cur.a), .operand_b_i(cur.b), .imm_i(cur.imm), .trans_id_i(cur.tid),
        .pc_i(cur.pc), .is_compressed_i(cur.comp),
        .alu_valid_i(cur.sel[0]), .branch_valid_i(cur.sel[1]),
        .csr_valid_i(cur.sel[2]), .mult_valid_i(cur.sel[3]),
        .predict_taken_i(cur.pred_taken), .predict_target_i(cur.pred_target),
        .csr_commit_i(cur.commit), .flu_valid_o(flu_valid), .flu_ready_o(flu_ready),
        .flu_result_o(flu_result), .flu_trans_id_o(flu_trans_id), .csr_addr_o(csr_addr),
        .resolve_valid_o(res_valid), .resolve_taken_o(res_taken),
        .resolve_target_o(res_target), .resolve_mispredict_o(res_mis));

    ex_flu_checker u_checker (
        .clk_i, .check_i(cur.chk), .test_i(cur_test),
        .valid_i(flu_valid), .ready_i(flu_ready), .res_valid_i(res_valid),
        .taken_i(res_taken), .mispredict_i(res_mis), .result_i(flu_result),
        .target_i(res_target), .trans_id_i(flu_trans_id), .csr_addr_i(csr_addr),
        .exp_valid_i(cur.exp_valid), .exp_ready_i(cur.exp_ready),
        .exp_res_valid_i(cur.exp_res_valid), .exp_taken_i(cur.exp_taken),
        .exp_mis_i(cur.exp_mis), .exp_csr_chk_i(cur.csr_chk),
        .exp_result_i(cur.exp_result), .exp_target_i(cur.exp_target),
        .exp_trans_id_i(cur.exp_tid), .exp_csr_addr_i(cur.exp_csr_addr),
        .tests_o(tests), .errors_o(errors));

    // --------------------------------------------------
    // Reference results
    // --------------------------------------------------
    function automatic logic [31:0] alu_ref(fu_op_e op, logic [31:0] a, logic [31:0] b);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLL:     return a << b[4:0];
            SRL:     return a >> b[4:0];
            // Vacated top bits filled with copies of the sign
            SRA:     return (a >> b[4:0]) | ({32{a[31]}} & ~(32'hFFFF_FFFF >> b[4:0]));
            SLT:     return {31'b0, $signed(a) < $signed(b)};
            default: return {31'b0, a < b};
        endcase
    endfunction

    function automatic logic [31:0] mult_ref(fu_op_e op, logic [31:0] a, logic [31:0] b);
        logic [63:0] p;
        case (op)
            MULHU:   p = {32'b0, a} * {32'b0, b};
            MULHSU:  p = 64'($signed(a)) * {32'b0, b};
            default: p = 64'($signed(a)) * 64'($signed(b));
        endcase
        return (op == MUL) ? p[31:0] : p[63:32];
    endfunction

    // Row defaults with the tag taken from its position
    function automatic entry_t blank(fu_op_e op, logic [3:0] sel);
        entry_t e;
        e = '0;
        e.op = op;
        e.sel = sel;
        e.tid = 3'(table_q.size());
        e.exp_tid = e.tid;
        e.chk = 1'b1;
        e.exp_valid = (sel != SEL_NONE);
        e.exp_ready = 1'b1;
        return e;
    endfunction

    task automatic random_row(fu_op_e op, logic [3:0] sel, logic flush);
        entry_t e;
        e = blank(op, sel);
        e.a = $random(seed);
        e.b = $random(seed);
        e.flush = flush;
        e.exp_valid = !flush;
        e.exp_result = (sel == SEL_MUL) ? mult_ref(op, e.a, e.b) : alu_ref(op, e.a, e.b);
        table_q.push_back(e);
    endtask

    task automatic branch_row(fu_op_e op, logic [31:0] a, logic [31:0] b, logic [31:0] imm,
                              logic [31:0] pc, logic comp, logic pt, logic [31:0] ptgt,
                              logic taken, logic [31:0] target, logic mis);
        entry_t e;
        e = blank(op, SEL_BR);
        e.a = a;
        e.b = b;
        e.imm = imm;
        e.pc = pc;
        e.comp = comp;
        e.pred_taken = pt;
        e.pred_target = ptgt;
        // Write-back carries the return address
        e.exp_result = pc + (comp ? 32'd2 : 32'd4);
        e.exp_res_valid = 1'b1;
        e.exp_taken = taken;
        e.exp_target = target;
        e.exp_mis = mis;
        table_q.push_back(e);
    endtask

    task automatic csr_row(logic [11:0] addr, logic [31:0] a);
        entry_t e;
        e = blank(CSR_RW, SEL_CSR);
        e.a = a;
        // Padding bits must not reach the address
        e.imm = {20'hA5A5A, addr};
        e.exp_result = a;
        table_q.push_back(e);
    endtask

    task automatic idle_row(logic commit, logic flush, logic ready, logic chk, logic [11:0] addr);
        entry_t e;
        e = blank(ADD, SEL_NONE);
        e.commit = commit;
        e.flush = flush;
        e.exp_ready = ready;
        e.csr_chk = chk;
        e.exp_csr_addr = addr;
        table_q.push_back(e);
    endtask

    task automatic build_table();
        fu_op_e alu_ops[10] = '{ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU};
        fu_op_e mul_ops[4] = '{MUL, MULH, MULHU, MULHSU};
        // Reset state
        idle_row(1'b0, 1'b0, 1'b1, 1'b0, 12'h0);
        foreach (alu_ops[k]) random_row(alu_ops[k], SEL_ALU, 1'b0);
        // op, a, b, offset, pc, compressed, predicted, expected taken/target/mispredict
        branch_row(EQ, 'h10, 'h10, 'h40, 'h1000, 1'b0, 1'b1, 'h1040, 1'b1, 'h1040, 1'b0);
        branch_row(NE, 'h5, 'h5, 'h40, 'h1000, 1'b0, 1'b1, 'h1040, 1'b0, 'h1004, 1'b1);
        branch_row(LTS, 'hFFFF_FFFF, 'h1, 'hFFFF_FFF8, 'h2000, 1'b1, 1'b0, 'h0, 1'b1,
                   'h1FF8, 1'b1);
        branch_row(GES, 'hFFFF_FFFF, 'h1, 'h10, 'h2000, 1'b0, 1'b0, 'h0, 1'b0, 'h2004, 1'b0);
        branch_row(LTU, 'hFFFF_FFFF, 'h1, 'h10, 'h3000, 1'b1, 1'b1, 'h3010, 1'b0,
                   'h3002, 1'b1);
        branch_row(GEU, 'hFFFF_FFFF, 'h1, 'h100, 'h3000, 1'b0, 1'b1, 'h3200, 1'b1,
                   'h3100, 1'b1);
        branch_row(JALR, 'h8001, 'h0, 'h20, 'h4000, 1'b0, 1'b1, 'h8020, 1'b1, 'h8020, 1'b0);
        branch_row(JALR, 'h5000, 'h0, 'hFFFF_FFFD, 'h4100, 1'b1, 1'b0, 'h0, 1'b1,
                   'h4FFC, 1'b1);
        // CSR fill, stall, commit, then a second address
        csr_row(12'h300, 32'hCAFE_0001);
        idle_row(1'b0, 1'b0, 1'b0, 1'b1, 12'h300);
        idle_row(1'b1, 1'b0, 1'b1, 1'b1, 12'h300);
        csr_row(12'h341, 32'h1234_5678);
        idle_row(1'b0, 1'b0, 1'b0, 1'b1, 12'h341);
        idle_row(1'b1, 1'b0, 1'b1, 1'b1, 12'h341);
        foreach (mul_ops[k]) random_row(mul_ops[k], SEL_MUL, 1'b0);
        // Flush kills the multiply and empties the buffer
        random_row(MUL, SEL_MUL, 1'b1);
        csr_row(12'h7C0, 32'h0BAD_F00D);
        idle_row(1'b0, 1'b1, 1'b0, 1'b1, 12'h7C0);
        idle_row(1'b0, 1'b0, 1'b1, 1'b0, 12'h0);
    endtask

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // --------------------------------------------------
    // Drive loop
    // --------------------------------------------------
    initial begin
        cur = '0;
        rst_ni = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        foreach (table_q[i]) begin
            @(negedge clk_i);
            // Hold back an issue while the port is blocked
            while (table_q[i].sel != SEL_NONE && !flu_ready) begin
                cur = '0;
                @(negedge clk_i);
            end
            cur_test = i;
            cur = table_q[i];
            if (cur.sel == SEL_MUL) begin
                cur.chk = 1'b0;
                cur.flush = 1'b0;
                // Free slot for the registered result
                @(negedge clk_i);
                cur = table_q[i];
                cur.sel = SEL_NONE;
                cur.tid = ~table_q[i].tid;
            end
        end
        @(negedge clk_i);
        cur = '0;
        $display("Summary: %0d tests checked, %0d errors", tests, errors);
        if (tests != table_q.size()) begin
            $display("Only %0d of %0d table rows were checked", tests, table_q.size());
        end
        if (errors == 0 && tests == table_q.size()) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Four cycles per row covers stalls and mult slots
    initial begin
        wait (table_ready);
        repeat (table_q.size() * 4 + 20) @(posedge clk_i);
        $display("Watchdog expired, the table did not complete in time");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: sources.f
+incdir+hdl
hdl/ex_op_pkg.sv
hdl/ex_data_pkg.sv
hdl/ex_alu.sv
hdl/ex_branch_unit.sv
hdl/ex_csr_buffer.sv
hdl/ex_mult.sv
hdl/ex_flu_top.sv
sim/ex_flu_checker.sv
sim/tb_ex_flu.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
    -f sources.f --top-module tb_ex_flu -Mdir obj_dir -o tb_ex_flu
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_ex_flu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# Result decided by the pass line in the log
if grep -qx "TESTBENCH PASSED" "$LOG"; then
    exit 0
fi
exit 1
